// File: flist.f
+incdir+common
common/core_types_pkg.sv
common/rv_isa_pkg.sv
design/reg_file.sv
design/alu.sv
design/mem_arbiter.sv
core/fetch_unit.sv
core/lsu.sv
core/core_ctrl.sv
design/rv_core_top.sv
sim/rv_core_assertions.sv
sim/rv_core_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module rv_core_tb -Mdir obj_dir -f flist.f

out=$(./obj_dir/Vrv_core_tb +verilator+error+limit+1000 2>&1) || true
echo "$out"

if grep -qx "Simulation finished: PASS" <<< "$out"; then
    exit 0
fi
exit 1

// File: sim/rv_core_tb.sv
// testbench for rv_core_top, memory model, program table, retire checks and watchdog
`timescale 1ns/10ps

module rv_core_tb
    import core_types_pkg::*;
    import rv_isa_pkg::*;
();

    localparam int N_ENTRIES = 22;  // last entry is the illegal word
    localparam int MEM_WORDS = 64;

    logic      clk = 1'b0;
    logic      reset_i;
    logic      mem_req_o, mem_we_o, retire_o, halt_o;
    addr_t     mem_addr_o, retire_pc_o;
    word_t     mem_wdata_o, mem_rdata_i, retire_wdata_o;
    reg_addr_t retire_rd_o;

    word_t     mem [MEM_WORDS];
    word_t     tbl_instr [N_ENTRIES];
    reg_addr_t tbl_rd [N_ENTRIES];     // expected retire rd
    word_t     tbl_val [N_ENTRIES];    // expected retire data
    logic      tbl_chk [N_ENTRIES];    // 0 = data not checked (store)
    int        n_fill = 0;
    int        errors = 0;
    int        mem_errs = 0;           // counted by the memory model

    rv_core_top dut0 (
        .clk(clk), .reset_i(reset_i),
        .mem_req_o(mem_req_o), .mem_we_o(mem_we_o), .mem_addr_o(mem_addr_o),
        .mem_wdata_o(mem_wdata_o), .mem_rdata_i(mem_rdata_i),
        .retire_o(retire_o), .retire_pc_o(retire_pc_o), .retire_rd_o(retire_rd_o),
        .retire_wdata_o(retire_wdata_o), .halt_o(halt_o)
    );

    bind rv_core_top rv_core_assertions u_assertions (
        .clk(clk), .reset_i(reset_i), .mem_req_i(mem_req_o), .mem_we_i(mem_we_o),
        .fetch_rvalid_i(fetch_rvalid), .ls_rvalid_i(ls_rvalid),
        .retire_i(retire_o), .halt_i(halt_o)
    );

    always #50 clk = ~clk;  // 100 ns period

    // rv32i encoders
    function automatic word_t rtype_word(logic [6:0] f7, reg_addr_t rs2, reg_addr_t rs1,
                                         logic [2:0] f3, reg_addr_t rd);
        return {f7, rs2, rs1, f3, rd, OP};
    endfunction

    function automatic word_t itype_word(logic [11:0] imm, reg_addr_t rs1, logic [2:0] f3,
                                         reg_addr_t rd, logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic word_t store_word(logic [11:0] imm, reg_addr_t rs2, reg_addr_t rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], STORE};  // sw
    endfunction

    function automatic word_t lui_word(logic [19:0] imm, reg_addr_t rd);
        return {imm, rd, LUI};
    endfunction

    task automatic push_entry(input word_t instr, input reg_addr_t rd, input word_t val,
                              input logic chk);
        tbl_instr[n_fill] = instr;
        tbl_rd[n_fill]    = rd;
        tbl_val[n_fill]   = val;
        tbl_chk[n_fill]   = chk;
        n_fill++;
    endtask

    // x1 = 5 and x2 = -3 seed the operands
    task automatic fill_table();
        push_entry(itype_word(12'd5, 5'd0, F3_ADD, 5'd1, OP_IMM), 5'd1, 32'h0000_0005, 1'b1);
        push_entry(itype_word(12'hffd, 5'd0, F3_ADD, 5'd2, OP_IMM), 5'd2, 32'hffff_fffd, 1'b1);
        push_entry(rtype_word(7'h00, 5'd2, 5'd1, F3_ADD, 5'd3), 5'd3, 32'h0000_0002, 1'b1);
        push_entry(rtype_word(7'h20, 5'd2, 5'd1, F3_ADD, 5'd4), 5'd4, 32'h0000_0008, 1'b1);
        push_entry(rtype_word(7'h00, 5'd2, 5'd1, F3_AND, 5'd5), 5'd5, 32'h0000_0005, 1'b1);
        push_entry(rtype_word(7'h00, 5'd2, 5'd1, F3_OR, 5'd6), 5'd6, 32'hffff_fffd, 1'b1);
        push_entry(rtype_word(7'h00, 5'd2, 5'd1, F3_XOR, 5'd7), 5'd7, 32'hffff_fff8, 1'b1);
        push_entry(rtype_word(7'h00, 5'd1, 5'd2, F3_SLT, 5'd8), 5'd8, 32'h0000_0001, 1'b1);
        push_entry(rtype_word(7'h00, 5'd2, 5'd1, F3_SLT, 5'd9), 5'd9, 32'h0000_0000, 1'b1);
        push_entry(rtype_word(7'h00, 5'd1, 5'd1, F3_SLL, 5'd10), 5'd10, 32'h0000_00a0, 1'b1);
        push_entry(rtype_word(7'h00, 5'd1, 5'd2, F3_SRL, 5'd11), 5'd11, 32'h07ff_ffff, 1'b1);
        push_entry(itype_word(12'h0f0, 5'd2, F3_AND, 5'd12, OP_IMM), 5'd12, 32'h0000_00f0, 1'b1);
        push_entry(itype_word(12'hf00, 5'd1, F3_OR, 5'd13, OP_IMM), 5'd13, 32'hffff_ff05, 1'b1);
        push_entry(itype_word(12'hfff, 5'd1, F3_XOR, 5'd14, OP_IMM), 5'd14, 32'hffff_fffa, 1'b1);
        push_entry(itype_word(12'hffe, 5'd2, F3_SLT, 5'd15, OP_IMM), 5'd15, 32'h0000_0001, 1'b1);
        push_entry(lui_word(20'h12345, 5'd16), 5'd16, 32'h1234_5000, 1'b1);
        push_entry(itype_word(12'd7, 5'd1, F3_ADD, 5'd0, OP_IMM), 5'd0, 32'h0000_000c, 1'b1);
        push_entry(itype_word(12'h055, 5'd0, F3_ADD, 5'd17, OP_IMM), 5'd17, 32'h0000_0055, 1'b1);
        push_entry(store_word(12'h080, 5'd16, 5'd0), 5'd0, 32'h0000_0000, 1'b0);
        push_entry(itype_word(12'h080, 5'd0, 3'b010, 5'd19, LOAD), 5'd19, 32'h1234_5000, 1'b1);
        push_entry(rtype_word(7'h00, 5'd17, 5'd19, F3_ADD, 5'd20), 5'd20, 32'h1234_5055, 1'b1);
        push_entry(32'hffff_ffff, 5'd0, 32'h0000_0000, 1'b0);  // opcode 7f is not decoded
    endtask

    task automatic expect_word(input string name, input word_t exp, input word_t got);
        assert (exp == got) else begin
            $display("ERR %0t %s exp %h got %h", $time, name, exp, got);
            errors++;
        end
    endtask

    // retire sampled mid cycle on the falling edge
    task automatic await_retire(output logic seen);
        int n;
        n = 0;
        seen = 1'b0;
        while (!seen && n < 8) begin
            @(negedge clk);
            seen = retire_o;
            n++;
        end
        assert (seen) else begin
            $display("no retire within 8 cycles at %0t", $time);
            errors++;
        end
    endtask

    task automatic check_halt();
        int n;
        n = 0;
        while (!halt_o && n < 8) begin
            @(negedge clk);
            assert (!retire_o) else begin
                $display("illegal word retired at %0t", $time);
                errors++;
            end
            n++;
        end
        assert (halt_o) else begin
            $display("core did not halt on the illegal word");
            errors++;
        end
        repeat (10) begin  // parked core keeps the bus quiet
            @(negedge clk);
            expect_word("halt_o", 32'd1, word_t'(halt_o));
            expect_word("retire_o", 32'd0, word_t'(retire_o));
            expect_word("mem_req_o", 32'd0, word_t'(mem_req_o));
        end
    endtask

    // memory model answers a read one cycle after the request
    initial begin
        logic       rd_pend;
        logic [5:0] rd_idx;
        mem_rdata_i = '0;
        #1;  // table is filled at time 0
        for (int k = 0; k < MEM_WORDS; k++) begin
            mem[k] = 32'ha5a5_0000 | word_t'(k * 4);
        end
        for (int k = 0; k < N_ENTRIES; k++) begin
            mem[k] = tbl_instr[k];
        end
        forever begin
            @(negedge clk);
            rd_pend = 1'b0;
            if (mem_req_o) begin
                assert (mem_addr_o[31:8] == '0) else begin
                    $display("access outside the 64-word memory at address %h", mem_addr_o);
                    mem_errs++;
                end
                if (mem_we_o) begin
                    mem[mem_addr_o[7:2]] = mem_wdata_o;  // write lands in the request cycle
                end else begin
                    rd_pend = 1'b1;
                    rd_idx  = mem_addr_o[7:2];
                end
            end
            @(posedge clk);
            #5 mem_rdata_i = rd_pend ? mem[rd_idx] : '0;
        end
    end

    initial begin
        repeat (N_ENTRIES * 4 + 20) @(posedge clk);
        $display("watchdog expired before the end of the program table");
        $display("Simulation finished: FAIL");
        $finish;
    end

    initial begin
        int   errs_before;
        int   failed;
        int   total;
        logic seen;
        failed  = 0;
        reset_i = 1'b1;
        fill_table();
        repeat (5) @(posedge clk);
        #5 reset_i = 1'b0;

        for (int i = 0; i < N_ENTRIES - 1; i++) begin
            errs_before = errors;
            await_retire(seen);
            if (seen) begin
                expect_word("retire_pc_o", word_t'(i * 4), retire_pc_o);
                expect_word("retire_rd_o", word_t'(tbl_rd[i]), word_t'(retire_rd_o));
                if (tbl_chk[i]) begin
                    expect_word("retire_wdata_o", tbl_val[i], retire_wdata_o);
                end
            end
            if (errors != errs_before) failed++;
            $display("entry %0d instr %h rd %0d %s", i, tbl_instr[i], tbl_rd[i],
                     (errors == errs_before) ? "ok" : "bad");
        end

        errs_before = errors;
        check_halt();
        expect_word("mem[32]", 32'h1234_5000, mem[32]);  // sw target at 0x80
        if (errors != errs_before) failed++;
        $display("entry %0d instr %h halt %s", N_ENTRIES - 1, tbl_instr[N_ENTRIES - 1],
                 (errors == errs_before) ? "ok" : "bad");

        total = errors + mem_errs + dut0.u_assertions.fail_cnt;
        $display("%0d entries, %0d passed, %0d failed, %0d errors in total",
                 N_ENTRIES, N_ENTRIES - failed, failed, total);
        if (total == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// File: sim/rv_core_assertions.sv
// concurrent checks on the memory bus, the retire pulse and the halt level
`timescale 1ns/10ps

module rv_core_assertions (
    input logic clk,
    input logic reset_i,
    input logic mem_req_i,
    input logic mem_we_i,
    input logic fetch_rvalid_i,
    input logic ls_rvalid_i,
    input logic retire_i,
    input logic halt_i
);

    int fail_cnt = 0;  // failed assertions so far

    // parked core stays off the bus
    no_req_when_halted: assert property (@(posedge clk) disable iff (reset_i)
        halt_i |-> !mem_req_i)
        else begin $error("memory request while halted"); fail_cnt++; end

    retire_is_pulse: assert property (@(posedge clk) disable iff (reset_i)
        retire_i |=> !retire_i)
        else begin $error("retire held longer than one cycle"); fail_cnt++; end

    // exactly one owner gets the read data
    read_gets_one_valid: assert property (@(posedge clk) disable iff (reset_i)
        (mem_req_i && !mem_we_i) |=> $onehot({fetch_rvalid_i, ls_rvalid_i}))
        else begin $error("read not followed by exactly one valid"); fail_cnt++; end

endmodule

// File: design/rv_core_top.sv
// core top level, ctrl, fetch, lsu, arbiter, register file and alu wired together
`timescale 1ns/10ps

module rv_core_top
    import core_types_pkg::*;
    import rv_isa_pkg::*;
(
    input  logic      clk,
    input  logic      reset_i,
    output logic      mem_req_o,
    output logic      mem_we_o,
    output addr_t     mem_addr_o,
    output word_t     mem_wdata_o,
    input  word_t     mem_rdata_i,   // one cycle after a read
    output logic      retire_o,
    output addr_t     retire_pc_o,
    output reg_addr_t retire_rd_o,
    output word_t     retire_wdata_o,
    output logic      halt_o
);

    // fetch side
    logic      fetch_start, pc_inc, fetch_req, fetch_rvalid;
    addr_t     fetch_addr, pc;
    word_t     instr;
    // load/store side
    logic      mem_start, ctrl_we, ls_req, ls_we, ls_rvalid;
    addr_t     ctrl_addr, ls_addr;
    word_t     ctrl_wdata, ls_wdata, load_data, bus_rdata;
    // register file and alu
    reg_addr_t rs1, rs2, rf_waddr;
    word_t     rs1_data, rs2_data, rf_wdata, imm, alu_res;
    logic      rf_we, use_imm;
    alu_op_e   alu_op;

    core_ctrl u_ctrl (
        .clk(clk), .reset_i(reset_i),
        .instr_i(instr), .fetch_rvalid_i(fetch_rvalid), .ls_rvalid_i(ls_rvalid),
        .load_data_i(load_data), .alu_res_i(alu_res),
        .rs1_data_i(rs1_data), .rs2_data_i(rs2_data), .pc_i(pc),
        .fetch_start_o(fetch_start), .pc_inc_o(pc_inc),
        .mem_start_o(mem_start), .mem_we_o(ctrl_we),
        .mem_addr_o(ctrl_addr), .mem_wdata_o(ctrl_wdata),
        .rs1_o(rs1), .rs2_o(rs2), .alu_op_o(alu_op), .imm_o(imm), .use_imm_o(use_imm),
        .rf_we_o(rf_we), .rf_waddr_o(rf_waddr), .rf_wdata_o(rf_wdata),
        .retire_o(retire_o), .halt_o(halt_o)
    );

    fetch_unit u_fetch (
        .clk(clk), .reset_i(reset_i), .start_i(fetch_start), .pc_inc_i(pc_inc),
        .rvalid_i(fetch_rvalid), .rdata_i(bus_rdata),
        .req_o(fetch_req), .addr_o(fetch_addr), .pc_o(pc), .instr_o(instr)
    );

    lsu u_lsu (
        .clk(clk), .reset_i(reset_i), .start_i(mem_start), .we_i(ctrl_we),
        .addr_i(ctrl_addr), .wdata_i(ctrl_wdata),
        .rvalid_i(ls_rvalid), .rdata_i(bus_rdata),
        .req_o(ls_req), .we_o(ls_we), .addr_o(ls_addr), .wdata_o(ls_wdata),
        .load_data_o(load_data)
    );

    mem_arbiter u_arb (
        .clk(clk), .reset_i(reset_i),
        .fetch_req_i(fetch_req), .fetch_addr_i(fetch_addr),
        .ls_req_i(ls_req), .ls_we_i(ls_we), .ls_addr_i(ls_addr), .ls_wdata_i(ls_wdata),
        .mem_req_o(mem_req_o), .mem_we_o(mem_we_o),
        .mem_addr_o(mem_addr_o), .mem_wdata_o(mem_wdata_o), .mem_rdata_i(mem_rdata_i),
        .rdata_o(bus_rdata), .fetch_rvalid_o(fetch_rvalid), .ls_rvalid_o(ls_rvalid)
    );

    reg_file u_rf (
        .clk(clk), .reset_i(reset_i),
        .we_i(rf_we), .waddr_i(rf_waddr), .wdata_i(rf_wdata),
        .raddr1_i(rs1), .raddr2_i(rs2), .rdata1_o(rs1_data), .rdata2_o(rs2_data)
    );

    alu u_alu (
        .op_i(alu_op), .a_i(rs1_data), .b_i(rs2_data), .imm_i(imm),
        .use_imm_i(use_imm), .res_o(alu_res)
    );

    // trace taps the register write port
    assign retire_pc_o    = pc;
    assign retire_rd_o    = rf_waddr;
    assign retire_wdata_o = rf_wdata;

endmodule

// File: core/core_ctrl.sv
// instruction decode, immediate generation and the fetch/exec/mem/retire fsm
`timescale 1ns/10ps

module core_ctrl
    import core_types_pkg::*;
    import rv_isa_pkg::*;
(
    input  logic      clk,
    input  logic      reset_i,
    input  word_t     instr_i,
    input  logic      fetch_rvalid_i,
    input  logic      ls_rvalid_i,
    input  word_t     load_data_i,
    input  word_t     alu_res_i,
    input  word_t     rs1_data_i,
    input  word_t     rs2_data_i,
    input  addr_t     pc_i,
    output logic      fetch_start_o,
    output logic      pc_inc_o,
    output logic      mem_start_o,
    output logic      mem_we_o,
    output addr_t     mem_addr_o,
    output word_t     mem_wdata_o,
    output reg_addr_t rs1_o,
    output reg_addr_t rs2_o,
    output alu_op_e   alu_op_o,
    output word_t     imm_o,
    output logic      use_imm_o,
    output logic      rf_we_o,
    output reg_addr_t rf_waddr_o,
    output word_t     rf_wdata_o,
    output logic      retire_o,
    output logic      halt_o
);

    ctrl_state_e state_q;
    ctrl_state_e state_d;
    opcode_e     opcode;
    logic [2:0]  funct3;
    reg_addr_t   rd;
    logic        is_op;
    logic        is_op_imm;
    logic        is_lui;
    logic        is_load;
    logic        is_store;
    logic        is_legal;
    logic [1:0]  ea_low;      // byte offset of lw/sw address
    logic        misaligned;
    logic        exec_ok;     // legal instr in EXEC
    logic        load_done;   // load data back this cycle

    // funct3 to alu op, sub only meaningful for r-type
    function automatic alu_op_e decode_f3(logic [2:0] f3, logic sub);
        alu_op_e op;
        case (f3)
            F3_ADD:  op = sub ? SUB : ADD;
            F3_SLL:  op = SLL;
            F3_SLT:  op = SLT;
            F3_XOR:  op = XOR;
            F3_SRL:  op = SRL;
            F3_OR:   op = OR;
            F3_AND:  op = AND;
            default: op = ADD;  // sltu not supported
        endcase
        return op;
    endfunction

    // fixed rv32i field positions
    assign opcode = opcode_e'(instr_i[6:0]);
    assign funct3 = instr_i[14:12];
    assign rd     = instr_i[11:7];
    assign rs1_o  = instr_i[19:15];
    assign rs2_o  = instr_i[24:20];

    assign is_op     = (opcode == OP);
    assign is_op_imm = (opcode == OP_IMM);
    assign is_lui    = (opcode == LUI);
    assign is_load   = (opcode == LOAD);
    assign is_store  = (opcode == STORE);
    assign is_legal  = is_op | is_op_imm | is_lui | is_load | is_store;

    // immediates, all sign extended from bit 31
    always_comb begin
        if (is_store) begin
            imm_o = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};  // s-type
        end else if (is_lui) begin
            imm_o = {instr_i[31:12], 12'b0};  // u-type
        end else begin
            imm_o = {{20{instr_i[31]}}, instr_i[31:20]};  // i-type
        end
    end

    always_comb begin
        if (is_op) begin
            alu_op_o = decode_f3(funct3, instr_i[F7_SUB_BIT]);
        end else if (is_op_imm) begin
            alu_op_o = decode_f3(funct3, 1'b0);
        end else if (is_lui) begin
            alu_op_o = PASS_B;
        end else begin
            alu_op_o = ADD;  // lw/sw address = rs1 + imm
        end
    end

    assign use_imm_o = ~is_op;

    // low two bits carry nothing in, so no need to wait for the adder
    assign ea_low     = rs1_data_i[1:0] + imm_o[1:0];
    assign misaligned = (pc_i[1:0] != 2'b00) | ((is_load | is_store) & (ea_low != 2'b00));

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q <= FETCH;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            FETCH:    state_d = MEM_WAIT;
            MEM_WAIT: begin
                if (fetch_rvalid_i) begin
                    state_d = EXEC;   // instr captured
                end else if (ls_rvalid_i) begin
                    state_d = FETCH;  // load written back
                end
            end
            EXEC: begin
                if (!is_legal || misaligned) begin
                    state_d = HALT;
                end else if (is_load) begin
                    state_d = MEM_WAIT;
                end else begin
                    state_d = FETCH;
                end
            end
            HALT:     state_d = HALT;  // only reset leaves
            default:  state_d = HALT;
        endcase
    end

    assign exec_ok   = (state_q == EXEC) & is_legal & ~misaligned;
    assign load_done = (state_q == MEM_WAIT) & ls_rvalid_i;

    assign fetch_start_o = (state_q == FETCH);
    assign mem_start_o   = exec_ok & (is_load | is_store);
    assign mem_we_o      = is_store;
    assign mem_addr_o    = alu_res_i;
    assign mem_wdata_o   = rs2_data_i;

    // writeback, store reports rd 0
    assign rf_we_o    = (exec_ok & (is_op | is_op_imm | is_lui)) | load_done;
    assign rf_waddr_o = is_store ? '0 : rd;
    assign rf_wdata_o = load_done ? load_data_i : alu_res_i;

    assign retire_o = (exec_ok & ~is_load) | load_done;  // lw retires a cycle later
    assign pc_inc_o = retire_o;
    assign halt_o   = (state_q == HALT);

endmodule

// File: core/lsu.sv
// load/store bus request generation and load data capture
`timescale 1ns/10ps

module lsu
    import core_types_pkg::*;
(
    input  logic  clk,
    input  logic  reset_i,
    input  logic  start_i,      // one pulse per lw or sw
    input  logic  we_i,         // 1 = store
    input  addr_t addr_i,       // rs1 + imm
    input  word_t wdata_i,      // rs2 for stores
    input  logic  rvalid_i,
    input  word_t rdata_i,
    output logic  req_o,
    output logic  we_o,
    output addr_t addr_o,
    output word_t wdata_o,
    output word_t load_data_o
);

    logic  ld_pend_q;  // load outstanding on the bus
    word_t load_q;

    // word accesses only, drop the byte offset
    assign req_o   = start_i;
    assign we_o    = start_i & we_i;
    assign addr_o  = {addr_i[$bits(addr_t)-1:2], 2'b00};
    assign wdata_o = wdata_i;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            ld_pend_q <= 1'b0;
        end else if (start_i && !we_i) begin
            ld_pend_q <= 1'b1;
        end else if (rvalid_i) begin
            ld_pend_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rvalid_i && ld_pend_q) begin
            load_q <= rdata_i;
        end
    end

    // same-cycle data goes straight through, else the held copy
    assign load_data_o = (rvalid_i && ld_pend_q) ? rdata_i : load_q;

endmodule

// File: core/fetch_unit.sv
// program counter, fetch request and instruction register
`timescale 1ns/10ps
`include "core_settings.svh"

module fetch_unit
    import core_types_pkg::*;
(
    input  logic  clk,
    input  logic  reset_i,
    input  logic  start_i,   // fetch pulse from ctrl
    input  logic  pc_inc_i,  // retire, step to next instr
    input  logic  rvalid_i,  // instr word on rdata_i
    input  word_t rdata_i,
    output logic  req_o,
    output addr_t addr_o,
    output addr_t pc_o,
    output word_t instr_o
);

    addr_t pc_q;
    word_t instr_q;  // held until the next fetch returns

    always_ff @(posedge clk) begin
        if (reset_i) begin
            pc_q <= `CORE_RESET_PC;
        end else if (pc_inc_i) begin
            pc_q <= pc_q + addr_t'(4);  // no branches, always sequential
        end
    end

    always_ff @(posedge clk) begin
        if (rvalid_i) begin
            instr_q <= rdata_i;
        end
    end

    assign req_o   = start_i;  // request in the same cycle
    assign addr_o  = pc_q;
    assign pc_o    = pc_q;
    assign instr_o = instr_q;

endmodule

// File: design/mem_arbiter.sv
// fixed priority arbiter for fetch and load/store onto one memory bus
`timescale 1ns/10ps

module mem_arbiter
    import core_types_pkg::*;
(
    input  logic  clk,
    input  logic  reset_i,
    input  logic  fetch_req_i,
    input  addr_t fetch_addr_i,
    input  logic  ls_req_i,
    input  logic  ls_we_i,
    input  addr_t ls_addr_i,
    input  word_t ls_wdata_i,
    output logic  mem_req_o,
    output logic  mem_we_o,
    output addr_t mem_addr_o,
    output word_t mem_wdata_o,
    input  word_t mem_rdata_i,
    output word_t rdata_o,         // shared read data to both masters
    output logic  fetch_rvalid_o,
    output logic  ls_rvalid_o
);

    logic rd_pend_q;   // read issued last cycle
    logic rd_ls_q;     // owner of that read, 1 = lsu

    // lsu wins, no added latency
    assign mem_req_o   = ls_req_i | fetch_req_i;
    assign mem_we_o    = ls_req_i & ls_we_i;
    assign mem_addr_o  = ls_req_i ? ls_addr_i : fetch_addr_i;
    assign mem_wdata_o = ls_wdata_i;  // only looked at on writes

    always_ff @(posedge clk) begin
        if (reset_i) begin
            rd_pend_q <= 1'b0;
            rd_ls_q   <= 1'b0;
        end else begin
            rd_pend_q <= mem_req_o & ~mem_we_o;
            rd_ls_q   <= ls_req_i;
        end
    end

    // memory answers one cycle after the read
    assign rdata_o        = mem_rdata_i;
    assign fetch_rvalid_o = rd_pend_q & ~rd_ls_q;
    assign ls_rvalid_o    = rd_pend_q & rd_ls_q;

endmodule

// File: design/alu.sv
// combinational alu with rs2 or immediate operand select
`timescale 1ns/10ps

module alu
    import core_types_pkg::*;
    import rv_isa_pkg::*;
(
    input  alu_op_e op_i,
    input  word_t   a_i,        // rs1 data
    input  word_t   b_i,        // rs2 data
    input  word_t   imm_i,      // decoded immediate
    input  logic    use_imm_i,  // 1 picks imm_i as operand b
    output word_t   res_o
);

    word_t      op_b;
    logic [4:0] shamt;  // shifts only look at 5 bits

    assign op_b  = use_imm_i ? imm_i : b_i;
    assign shamt = op_b[4:0];

    always_comb begin
        case (op_i)
            ADD:     res_o = a_i + op_b;
            SUB:     res_o = a_i - op_b;
            AND:     res_o = a_i & op_b;
            OR:      res_o = a_i | op_b;
            XOR:     res_o = a_i ^ op_b;
            SLT:     res_o = ($signed(a_i) < $signed(op_b)) ? word_t'(1) : '0;
            SLL:     res_o = a_i << shamt;
            SRL:     res_o = a_i >> shamt;  // logical, no sra
            PASS_B:  res_o = op_b;
            default: res_o = '0;
        endcase
    end

endmodule

// File: design/reg_file.sv
// general purpose register file, two read ports, one write port, x0 zero, write bypass
`timescale 1ns/10ps
`include "core_settings.svh"

module reg_file
    import core_types_pkg::*;
(
    input  logic      clk,
    input  logic      reset_i,
    input  logic      we_i,      // write strobe from ctrl
    input  reg_addr_t waddr_i,
    input  word_t     wdata_i,
    input  reg_addr_t raddr1_i,  // rs1
    input  reg_addr_t raddr2_i,  // rs2
    output word_t     rdata1_o,
    output word_t     rdata2_o
);

    word_t regs_q [`CORE_REG_NUM];  // storage, entry 0 never written
    logic  wr_live;                 // write that lands this cycle

    assign wr_live = we_i && (waddr_i != '0);

    always_ff @(posedge clk) begin
        if (!reset_i && wr_live) begin
            regs_q[waddr_i] <= wdata_i;
        end
    end

    // x0 first, then same-cycle write, then array
    assign rdata1_o = (raddr1_i == '0)                  ? '0 :
                      (wr_live && raddr1_i == waddr_i)  ? wdata_i :
                                                          regs_q[raddr1_i];

    assign rdata2_o = (raddr2_i == '0)                  ? '0 :
                      (wr_live && raddr2_i == waddr_i)  ? wdata_i :
                                                          regs_q[raddr2_i];

endmodule

// File: common/rv_isa_pkg.sv
// rv32i opcode, funct3 and funct7 encodings and the alu operation enum
package rv_isa_pkg;

    // major opcodes, instr[6:0]
    typedef enum logic [6:0] {
        OP     = 7'b0110011,  // r-type alu
        OP_IMM = 7'b0010011,  // i-type alu
        LUI    = 7'b0110111,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011
    } opcode_e;

    typedef enum logic [3:0] {
        ADD    = 4'd0,
        SUB    = 4'd1,
        AND    = 4'd2,
        OR     = 4'd3,
        XOR    = 4'd4,
        SLT    = 4'd5,  // signed compare
        SLL    = 4'd6,
        SRL    = 4'd7,
        PASS_B = 4'd8   // lui path
    } alu_op_e;

    // funct3 of op / op_imm
    localparam logic [2:0] F3_ADD = 3'b000;  // add, sub, addi
    localparam logic [2:0] F3_SLL = 3'b001;
    localparam logic [2:0] F3_SLT = 3'b010;
    localparam logic [2:0] F3_XOR = 3'b100;
    localparam logic [2:0] F3_SRL = 3'b101;  // srl, sra shares it
    localparam logic [2:0] F3_OR  = 3'b110;
    localparam logic [2:0] F3_AND = 3'b111;

    localparam int F7_SUB_BIT = 30;  // instr bit selecting sub / sra

endpackage

// File: common/core_types_pkg.sv
// width typedefs and the sequencer state enum of the core
`include "core_settings.svh"

package core_types_pkg;

    typedef logic [`CORE_XLEN-1:0]   word_t;      // data or instruction word
    typedef logic [`CORE_XLEN-1:0]   addr_t;      // byte address
    typedef logic [`CORE_REG_AW-1:0] reg_addr_t;  // gpr index

    // one instruction in flight, so four states are enough
    typedef enum logic [1:0] {
        FETCH    = 2'd0,  // fetch request on the bus
        EXEC     = 2'd1,  // decode, alu, writeback or mem request
        MEM_WAIT = 2'd2,  // waiting on read data, instr or load
        HALT     = 2'd3   // illegal instr seen, parked
    } ctrl_state_e;

endpackage

// File: common/core_settings.svh
// core width, register file size and reset pc macros
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

`define CORE_XLEN      32      // data and address width
`define CORE_REG_NUM   32      // general purpose registers
`define CORE_REG_AW    5       // gpr index width
`define CORE_RESET_PC  32'h0   // first fetch address

`endif
